// File: source/imu_link_pkg.sv
`default_nettype none

package imu_link_pkg;

    // ==========================================================
    // Frame format
    // ==========================================================
    localparam int frame_bytes = 16;
    localparam int byte_idx_w  = $clog2(frame_bytes);
    // One extra bit so the counter can sit at 16 after a full frame
    localparam int byte_cnt_w  = byte_idx_w + 1;

    localparam logic [7:0]  header_byte = 8'hAA;
    // 1.0 in Q14
    localparam logic [15:0] q14_one     = 16'd16384;

    // Fields in wire order, header in the top byte
    typedef struct packed {
        logic [7:0]         header;
        logic signed [15:0] roll;
        logic signed [15:0] pitch;
        logic signed [15:0] yaw;
        logic signed [15:0] gyro_x;
        logic signed [15:0] gyro_y;
        logic signed [15:0] gyro_z;
        logic [7:0]         flags;
        logic [15:0]        reserved;
    } frame_fields_t;

    // Receiver fills bytes, parser reads fields
    typedef union packed {
        logic [0:frame_bytes-1][7:0] raw;
        frame_fields_t               fields;
    } frame_u;

    // Orientation record seen by the register block
    typedef struct packed {
        logic signed [15:0] quat_w;
        logic signed [15:0] quat_x;
        logic signed [15:0] quat_y;
        logic signed [15:0] quat_z;
        logic signed [15:0] gyro_x;
        logic signed [15:0] gyro_y;
        logic signed [15:0] gyro_z;
        logic               quat_valid;
        logic               gyro_valid;
    } imu_sample_t;

    // One-hot frame outcome, valid for a single cycle
    typedef struct packed {
        logic good;
        logic bad_header;
        logic short_frame;
    } frame_event_t;

    // ==========================================================
    // AXI4-Lite register port
    // ==========================================================
    localparam int axil_addr_w = 8;
    localparam int axil_data_w = 32;

    // Master to slave
    typedef struct packed {
        logic                     awvalid;
        logic [axil_addr_w-1:0]   awaddr;
        logic                     wvalid;
        logic [axil_data_w-1:0]   wdata;
        logic [axil_data_w/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [axil_addr_w-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [axil_data_w-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // Register map
    localparam logic [axil_addr_w-1:0] reg_status      = 8'h00;
    localparam logic [axil_addr_w-1:0] reg_good_count  = 8'h04;
    localparam logic [axil_addr_w-1:0] reg_error_count = 8'h08;
    localparam logic [axil_addr_w-1:0] reg_quat_wx     = 8'h0C;
    localparam logic [axil_addr_w-1:0] reg_quat_yz     = 8'h10;
    localparam logic [axil_addr_w-1:0] reg_gyro_xy     = 8'h14;
    localparam logic [axil_addr_w-1:0] reg_gyro_z      = 8'h18;
    localparam logic [axil_addr_w-1:0] reg_control     = 8'h1C;

endpackage

`default_nettype wire

// File: source/spi_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_rx (
    input  logic                 spi_sck,
    input  logic                 spi_ss_n,
    input  logic                 spi_mosi,
    output imu_link_pkg::frame_u rx_frame,
    output logic                 rx_full
);

    // ==========================================================
    // SCK domain, SPI mode 0, MSB first
    // ==========================================================

    // Bits gathered so far in the current byte
    logic [6:0] shift;
    // Bit position inside the byte
    logic [2:0] bit_cnt;
    // Bytes stored so far, stops at frame_bytes
    logic [imu_link_pkg::byte_cnt_w-1:0] byte_cnt;

    logic byte_done;
    logic frame_open;
    logic last_byte;
    logic first_edge;
    logic [7:0] new_byte;

    // Eighth bit of a byte arrives on this edge
    assign byte_done  = (bit_cnt == 3'd7);
    // Room left in the buffer
    assign frame_open = (byte_cnt < imu_link_pkg::byte_cnt_w'(imu_link_pkg::frame_bytes));
    assign last_byte  = (byte_cnt == imu_link_pkg::byte_cnt_w'(imu_link_pkg::frame_bytes - 1));
    // Counters are only both zero on the opening edge of a frame
    assign first_edge = (bit_cnt == 3'd0) && (byte_cnt == '0);
    // Completed byte, MSB received first
    assign new_byte   = {shift, spi_mosi};

    // Counters and shifter, cleared while deselected
    always_ff @(posedge spi_sck or posedge spi_ss_n) begin
        if (spi_ss_n) begin
            shift    <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
            if (byte_done) begin
                shift <= '0;
                // Extra bytes past the frame are dropped
                if (frame_open) begin
                    byte_cnt <= byte_cnt + imu_link_pkg::byte_cnt_w'(1);
                end
            end else begin
                shift <= {shift[5:0], spi_mosi};
            end
        end
    end

    // ==========================================================
    // Frame buffer and full flag
    // ==========================================================
    // Both stay put after the select rises so the clk side
    // can copy them; the full flag drops only once the next
    // frame starts clocking
    always_ff @(posedge spi_sck) begin
        if (!spi_ss_n) begin
            if (byte_done && frame_open) begin
                // Byte 0 lands in the top of the word
                rx_frame.raw[byte_cnt[imu_link_pkg::byte_idx_w-1:0]] <= new_byte;
            end
            if (byte_done && last_byte) begin
                rx_full <= 1'b1;
            end else if (first_edge) begin
                rx_full <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/frame_cdc.sv
`timescale 1ns/1ps
`default_nettype none

module frame_cdc (
    input  logic                 clk,
    input  logic                 cs_n,
    input  logic                 spi_ss_n,
    input  imu_link_pkg::frame_u rx_frame,
    input  logic                 rx_full,
    output logic                 snap_valid,
    output imu_link_pkg::frame_u snap_frame,
    output logic                 snap_full
);

    // ==========================================================
    // Slave select into the clk domain
    // ==========================================================

    // Two-flop synchronizer
    logic ss_meta;
    logic ss_sync;
    // Previous synchronized value for edge detect
    logic ss_prev;
    logic ss_rise;

    // Idle bus has the select high, so preset to 1
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            ss_meta <= 1'b1;
            ss_sync <= 1'b1;
            ss_prev <= 1'b1;
        end else begin
            ss_meta <= spi_ss_n;
            ss_sync <= ss_meta;
            ss_prev <= ss_sync;
        end
    end

    // End of a transfer
    assign ss_rise = ss_sync && !ss_prev;

    // ==========================================================
    // Snapshot
    // ==========================================================

    // Single-cycle strobe, one per deselect
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            snap_valid <= 1'b0;
        end else begin
            snap_valid <= ss_rise;
        end
    end

    // SCK side is idle while deselected
    // so the buffer and flag are quiet here
    always_ff @(posedge clk) begin
        if (ss_rise) begin
            snap_frame <= rx_frame;
            snap_full  <= rx_full;
        end
    end

endmodule

`default_nettype wire

// File: source/imu_frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

module imu_frame_parser (
    input  logic                       clk,
    input  logic                       cs_n,
    input  logic                       snap_valid,
    input  imu_link_pkg::frame_u       snap_frame,
    input  logic                       snap_full,
    output imu_link_pkg::frame_event_t frame_event,
    output imu_link_pkg::imu_sample_t  sample,
    output logic                       initialized,
    output logic                       error
);

    logic                      header_ok;
    imu_link_pkg::imu_sample_t next_sample;

    assign header_ok = (snap_frame.fields.header == imu_link_pkg::header_byte);

    // Map fields onto the orientation record
    always_comb begin
        // No Euler conversion, w held at unity
        next_sample.quat_w     = imu_link_pkg::q14_one;
        // Roll, pitch, yaw go straight into x, y, z
        next_sample.quat_x     = snap_frame.fields.roll;
        next_sample.quat_y     = snap_frame.fields.pitch;
        next_sample.quat_z     = snap_frame.fields.yaw;
        // Gyro rates pass through
        next_sample.gyro_x     = snap_frame.fields.gyro_x;
        next_sample.gyro_y     = snap_frame.fields.gyro_y;
        next_sample.gyro_z     = snap_frame.fields.gyro_z;
        // Flags bit 0 marks Euler data, bit 1 gyro data
        next_sample.quat_valid = snap_frame.fields.flags[0];
        next_sample.gyro_valid = snap_frame.fields.flags[1];
    end

    // ==========================================================
    // Classification, one cycle after the snapshot
    // ==========================================================
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            frame_event <= '0;
            sample      <= '0;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            // Event is a pulse
            frame_event <= '0;
            if (snap_valid) begin
                if (!snap_full) begin
                    // Short frame touches neither sample nor status
                    frame_event.short_frame <= 1'b1;
                end else if (header_ok) begin
                    frame_event.good <= 1'b1;
                    sample           <= next_sample;
                    initialized      <= 1'b1;
                    error            <= 1'b0;
                end else begin
                    // Wrong header keeps the old sample
                    frame_event.bad_header <= 1'b1;
                    initialized            <= 1'b0;
                    error                  <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/imu_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module imu_axil_regs (
    input  logic                       clk,
    input  logic                       cs_n,
    input  imu_link_pkg::axil_req_t    axil_req,
    output imu_link_pkg::axil_rsp_t    axil_rsp,
    input  imu_link_pkg::frame_event_t frame_event,
    input  imu_link_pkg::imu_sample_t  sample,
    input  logic                       initialized,
    input  logic                       error,
    output logic                       irq
);

    // Write response state
    logic       bvalid;
    logic [1:0] bresp;
    // Read response state
    logic       rvalid;
    logic [1:0] rresp;
    logic [imu_link_pkg::axil_data_w-1:0] rdata;

    logic [31:0] good_count;
    logic [31:0] error_count;

    logic wr_accept;
    logic wr_ctrl;
    logic clear_counts;
    logic clear_irq;
    logic rd_accept;
    logic rd_err;
    logic bad_frame;
    logic [imu_link_pkg::axil_data_w-1:0] rd_data;

    // ==========================================================
    // Handshakes
    // ==========================================================
    // Address and data taken together, blocked by a pending response
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_accept = axil_req.arvalid && !rvalid;
    assign wr_ctrl   = wr_accept && (axil_req.awaddr == imu_link_pkg::reg_control);
    // Control bits live in the low byte lane
    assign clear_counts = wr_ctrl && axil_req.wstrb[0] && axil_req.wdata[0];
    assign clear_irq    = wr_ctrl && axil_req.wstrb[0] && axil_req.wdata[1];
    assign bad_frame    = frame_event.bad_header || frame_event.short_frame;

    always_comb begin
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = !rvalid;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

    // ==========================================================
    // Counters and interrupt
    // ==========================================================
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            good_count  <= '0;
            error_count <= '0;
            irq         <= 1'b0;
        end else begin
            // A frame in the clear cycle still counts
            if (clear_counts) begin
                good_count  <= {31'd0, frame_event.good};
                error_count <= {31'd0, bad_frame};
            end else begin
                if (frame_event.good) begin
                    good_count <= good_count + 32'd1;
                end
                if (bad_frame) begin
                    error_count <= error_count + 32'd1;
                end
            end
            // Set beats clear
            if (frame_event.good) begin
                irq <= 1'b1;
            end else if (clear_irq) begin
                irq <= 1'b0;
            end
        end
    end

    // Read mux
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (axil_req.araddr)
            imu_link_pkg::reg_status: begin
                rd_data = {27'd0, irq, sample.gyro_valid, sample.quat_valid,
                           error, initialized};
            end
            imu_link_pkg::reg_good_count:  rd_data = good_count;
            imu_link_pkg::reg_error_count: rd_data = error_count;
            imu_link_pkg::reg_quat_wx:     rd_data = {sample.quat_w, sample.quat_x};
            imu_link_pkg::reg_quat_yz:     rd_data = {sample.quat_y, sample.quat_z};
            imu_link_pkg::reg_gyro_xy:     rd_data = {sample.gyro_x, sample.gyro_y};
            // Sign-extend the lone rate
            imu_link_pkg::reg_gyro_z: rd_data = {{16{sample.gyro_z[15]}}, sample.gyro_z};
            default:                  rd_err  = 1'b1;
        endcase
    end

    // ==========================================================
    // Response channels
    // ==========================================================
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload, captured at acceptance
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_ctrl ? imu_link_pkg::axi_resp_okay : imu_link_pkg::axi_resp_slverr;
        end
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_err ? imu_link_pkg::axi_resp_slverr : imu_link_pkg::axi_resp_okay;
        end
    end

endmodule

`default_nettype wire

// File: source/imu_spi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module imu_spi_bridge (
    input  logic                    clk,
    input  logic                    cs_n,
    input  logic                    spi_sck,
    input  logic                    spi_ss_n,
    input  logic                    spi_mosi,
    input  imu_link_pkg::axil_req_t axil_req,
    output imu_link_pkg::axil_rsp_t axil_rsp,
    output logic                    irq
);

    // SCK domain to clk domain
    imu_link_pkg::frame_u       rx_frame;
    logic                       rx_full;
    // Snapshot to parser
    logic                       snap_valid;
    imu_link_pkg::frame_u       snap_frame;
    logic                       snap_full;
    // Parser to registers
    imu_link_pkg::frame_event_t frame_event;
    imu_link_pkg::imu_sample_t  sample;
    logic                       initialized;
    logic                       error;

    spi_frame_rx i_spi_frame_rx (
        .spi_sck  (spi_sck),
        .spi_ss_n (spi_ss_n),
        .spi_mosi (spi_mosi),
        .rx_frame (rx_frame),
        .rx_full  (rx_full)
    );

    frame_cdc i_frame_cdc (
        .clk        (clk),
        .cs_n       (cs_n),
        .spi_ss_n   (spi_ss_n),
        .rx_frame   (rx_frame),
        .rx_full    (rx_full),
        .snap_valid (snap_valid),
        .snap_frame (snap_frame),
        .snap_full  (snap_full)
    );

    imu_frame_parser i_imu_frame_parser (
        .clk         (clk),
        .cs_n        (cs_n),
        .snap_valid  (snap_valid),
        .snap_frame  (snap_frame),
        .snap_full   (snap_full),
        .frame_event (frame_event),
        .sample      (sample),
        .initialized (initialized),
        .error       (error)
    );

    imu_axil_regs i_imu_axil_regs (
        .clk         (clk),
        .cs_n        (cs_n),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .frame_event (frame_event),
        .sample      (sample),
        .initialized (initialized),
        .error       (error),
        .irq         (irq)
    );

endmodule

`default_nettype wire

// File: tb/imu_spi_bridge_sva.sv
`timescale 1ns/1ps
`default_nettype none

module imu_spi_bridge_sva (
    input logic                    clk,
    input logic                    cs_n,
    input imu_link_pkg::axil_req_t axil_req,
    input imu_link_pkg::axil_rsp_t axil_rsp,
    input logic                    irq
);

    // ==========================================================
    // AXI4-Lite response channels
    // ==========================================================

    // Read data and response frozen while the master stalls
    property read_held;
        @(posedge clk) disable iff (cs_n)
        axil_rsp.rvalid && !axil_req.rready |=>
            axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp);
    endproperty

    // Write response waits for bready
    property write_held;
        @(posedge clk) disable iff (cs_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid;
    endproperty

    // Nothing pending and no interrupt while in reset
    property quiet_in_reset;
        @(posedge clk)
        cs_n |-> !axil_rsp.rvalid && !axil_rsp.bvalid && !irq;
    endproperty

    a_read_held: assert property (read_held)
        else $error("rvalid or rdata changed before rready");
    a_write_held: assert property (write_held)
        else $error("bvalid dropped before bready");
    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("rvalid, bvalid or irq high during reset");

endmodule

bind imu_axil_regs imu_spi_bridge_sva i_imu_spi_bridge_sva (
    .clk      (clk),
    .cs_n     (cs_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .irq      (irq)
);

`default_nettype wire

// File: tb/imu_spi_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module imu_spi_bridge_tb;

    // ==========================================================
    // Timing
    // ==========================================================
    localparam time clk_period = 40;
    // Half of the 200 ns SCK period
    localparam time sck_half   = 100;
    // One full frame on the wire
    localparam time frame_time = 16 * 8 * 2 * sck_half;
    // Eight frames, doubled, plus bus traffic
    localparam time watchdog_time = 8 * frame_time * 2 + 200_000;

    logic                    clk;
    logic                    cs_n;
    logic                    spi_sck;
    logic                    spi_ss_n;
    logic                    spi_mosi;
    imu_link_pkg::axil_req_t axil_req;
    imu_link_pkg::axil_rsp_t axil_rsp;
    logic                    irq;

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     errors_at_start;

    // Frame on the wire, byte 0 sent first
    logic [7:0]  frame_data [0:15];
    // Roll, pitch, yaw, gyro x, y, z of the frame being sent
    logic [15:0] new_val [0:5];
    logic [7:0]  new_flags;

    // Model of what the registers should hold
    logic [15:0] exp_w;
    logic [15:0] exp_val [0:5];
    logic [31:0] exp_good;
    logic [31:0] exp_bad;
    logic        exp_init;
    logic        exp_error;
    logic        exp_qv;
    logic        exp_gv;
    logic        exp_irq;

    imu_spi_bridge i_imu_spi_bridge (
        .clk      (clk),
        .cs_n     (cs_n),
        .spi_sck  (spi_sck),
        .spi_ss_n (spi_ss_n),
        .spi_mosi (spi_mosi),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_time);
        $display("timeout: run did not finish within %0t", watchdog_time);
        $display("FAIL: see errors above");
        $finish;
    end

    // ==========================================================
    // Checks and bookkeeping
    // ==========================================================
    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
    endtask

    // ==========================================================
    // AXI4-Lite master
    // ==========================================================
    task automatic axil_read(input logic [7:0] addr, input logic [1:0] exp_resp,
                             output logic [31:0] data);
        int cycles;
        @(posedge clk);
        #2;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        cycles = 0;
        @(negedge clk);
        while (!axil_rsp.arready && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!axil_rsp.arready) begin
            $display("read of address %h was never accepted", addr);
            errors++;
        end
        @(posedge clk);
        #2;
        axil_req.arvalid = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!axil_rsp.rvalid) begin
            $display("read of address %h got no response", addr);
            errors++;
        end
        data = axil_rsp.rdata;
        if (axil_rsp.rresp !== exp_resp) begin
            $display("error at %0t: rresp is %b, expected %b", $time, axil_rsp.rresp, exp_resp);
            errors++;
        end
        // Stall the response for a few cycles
        repeat (3) @(posedge clk);
        #2;
        axil_req.rready = 1'b1;
        @(posedge clk);
        #2;
        axil_req.rready = 1'b0;
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
        int cycles;
        @(posedge clk);
        #2;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hF;
        cycles = 0;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready) && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            $display("write to address %h was never accepted", addr);
            errors++;
        end
        @(posedge clk);
        #2;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!axil_rsp.bvalid) begin
            $display("write to address %h got no response", addr);
            errors++;
        end
        if (axil_rsp.bresp !== exp_resp) begin
            $display("error at %0t: bresp is %b, expected %b", $time, axil_rsp.bresp, exp_resp);
            errors++;
        end
        // Stall the write response for a few cycles
        repeat (3) @(posedge clk);
        #2;
        axil_req.bready = 1'b1;
        @(posedge clk);
        #2;
        axil_req.bready = 1'b0;
    endtask

    task automatic check_reg(input logic [7:0] addr, input string name,
                             input logic [31:0] exp);
        logic [31:0] data;
        axil_read(addr, 2'b00, data);
        compare_word(name, data, exp);
    endtask

    // Every register against the model, plus the irq pin
    task automatic check_registers();
        logic [31:0] status;
        status = {27'd0, exp_irq, exp_gv, exp_qv, exp_error, exp_init};
        check_reg(8'h00, "reg_status", status);
        check_reg(8'h04, "reg_good_count", exp_good);
        check_reg(8'h08, "reg_error_count", exp_bad);
        check_reg(8'h0C, "reg_quat_wx", {exp_w, exp_val[0]});
        check_reg(8'h10, "reg_quat_yz", {exp_val[1], exp_val[2]});
        check_reg(8'h14, "reg_gyro_xy", {exp_val[3], exp_val[4]});
        check_reg(8'h18, "reg_gyro_z", {{16{exp_val[5][15]}}, exp_val[5]});
        @(negedge clk);
        if (irq !== exp_irq) begin
            $display("error at %0t: irq is %b, expected %b", $time, irq, exp_irq);
            errors++;
        end
    endtask

    // ==========================================================
    // SPI master, mode 0, MSB first
    // ==========================================================
    task automatic build_frame(input logic [7:0] header, input logic [7:0] flags);
        int i;
        frame_data[0] = header;
        for (i = 0; i < 6; i++) begin
            new_val[i] = 16'($random(seed));
            frame_data[1 + 2 * i] = new_val[i][15:8];
            frame_data[2 + 2 * i] = new_val[i][7:0];
        end
        frame_data[13] = flags;
        // Reserved bytes carry noise
        frame_data[14] = 8'($random(seed));
        frame_data[15] = 8'($random(seed));
        new_flags = flags;
    endtask

    task automatic send_frame(input int num_bytes);
        int b;
        int k;
        @(posedge clk);
        #2;
        spi_ss_n = 1'b0;
        for (b = 0; b < num_bytes; b++) begin
            for (k = 7; k >= 0; k--) begin
                // Data moves while SCK is low
                spi_mosi = frame_data[b][k];
                #(sck_half);
                spi_sck = 1'b1;
                #(sck_half);
                spi_sck = 1'b0;
            end
        end
        #(sck_half);
        spi_ss_n = 1'b1;
        spi_mosi = 1'b0;
        // Crossing plus parser plus registers, with slack
        repeat (12) @(posedge clk);
    endtask

    // Model update for an accepted frame
    task automatic expect_good();
        int i;
        for (i = 0; i < 6; i++) begin
            exp_val[i] = new_val[i];
        end
        exp_w     = 16'd16384;
        exp_good  = exp_good + 32'd1;
        exp_init  = 1'b1;
        exp_error = 1'b0;
        exp_qv    = new_flags[0];
        exp_gv    = new_flags[1];
        exp_irq   = 1'b1;
    endtask

    // ==========================================================
    // Tests
    // ==========================================================
    task automatic test_reset();
        start_test();
        check_registers();
        finish_test("reset");
    endtask

    task automatic test_good_frame();
        start_test();
        build_frame(8'hAA, 8'h03);
        send_frame(16);
        expect_good();
        check_registers();
        finish_test("good_frame");
    endtask

    task automatic test_bad_header();
        start_test();
        build_frame(8'h55, 8'h03);
        send_frame(16);
        // Sample stays from the last good frame
        exp_bad   = exp_bad + 32'd1;
        exp_init  = 1'b0;
        exp_error = 1'b1;
        check_registers();
        finish_test("bad_header");
    endtask

    task automatic test_short_frame();
        start_test();
        build_frame(8'hAA, 8'h03);
        send_frame(10);
        exp_bad = exp_bad + 32'd1;
        check_registers();
        finish_test("short_frame");
    endtask

    task automatic test_flags();
        int f;
        start_test();
        for (f = 0; f < 3; f++) begin
            build_frame(8'hAA, 8'(f));
            send_frame(16);
            expect_good();
            check_registers();
        end
        finish_test("flags");
    endtask

    task automatic test_control();
        logic [31:0] data;
        start_test();
        // Read-only address refuses the write and keeps its state
        axil_write(8'h00, 32'h3, 2'b10);
        check_registers();
        axil_write(8'h1C, 32'h3, 2'b00);
        exp_good = 32'd0;
        exp_bad  = 32'd0;
        exp_irq  = 1'b0;
        check_registers();
        // Hole in the map
        axil_read(8'h20, 2'b10, data);
        compare_word("rdata at 8'h20", data, 32'd0);
        finish_test("control");
    endtask

    initial begin
        seed         = 32'h759d1040;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cs_n         = 1'b1;
        spi_sck      = 1'b0;
        spi_ss_n     = 1'b1;
        spi_mosi     = 1'b0;
        axil_req     = '0;
        exp_w        = 16'd0;
        for (int i = 0; i < 6; i++) begin
            exp_val[i] = 16'd0;
        end
        exp_good  = 32'd0;
        exp_bad   = 32'd0;
        exp_init  = 1'b0;
        exp_error = 1'b0;
        exp_qv    = 1'b0;
        exp_gv    = 1'b0;
        exp_irq   = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        cs_n = 1'b0;

        test_reset();
        test_good_frame();
        test_bad_header();
        test_short_frame();
        test_flags();
        test_control();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: imu_spi_bridge.f
source/imu_link_pkg.sv
source/spi_frame_rx.sv
source/frame_cdc.sv
source/imu_frame_parser.sv
source/imu_axil_regs.sv
source/imu_spi_bridge.sv
tb/imu_spi_bridge_sva.sv
tb/imu_spi_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module imu_spi_bridge_tb \
    -Mdir obj_dir \
    -f imu_spi_bridge.f

./obj_dir/Vimu_spi_bridge_tb | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    exit 0
fi
exit 1
